// ==== common/vmul_pkg.sv ====
// Shared definitions for the vector multiply unit.
// One 256-bit register group is split over four 64-bit lanes.
// The vector length counts elements of the selected width and ranges 0 to 32.

package vmul_pkg;

    ////////////////////
    // sizes
    ////////////////////

    localparam int NUM_LANES    = 4;
    localparam int LANE_W       = 64;
    localparam int VREG_W       = NUM_LANES * LANE_W;
    localparam int VREG_BYTES   = VREG_W / 8;
    localparam int VL_W         = 6;

    // clock edges from lane input to lane output
    localparam int LANE_LATENCY = 3;

    ////////////////////
    // encodings
    ////////////////////

    typedef enum logic [1:0] {
        VMUL    = 2'd0,
        VMULH   = 2'd1,
        VMULHU  = 2'd2,
        VMULHSU = 2'd3
    } instr_type_t;

    // encoding is log2 of the element size in bytes
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    ////////////////////
    // data types
    ////////////////////

    typedef logic [LANE_W-1:0] bus64_t;

    // one lane word under each element width
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } elem64_u;

endpackage

// ==== vmul_unit/vmul_dispatch.sv ====
// Input stage of the multiply unit. Operands are captured only on valid_i.
// vl_i is not clamped, so it must not exceed the element count of the group.

module vmul_dispatch (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  logic                                        valid_i,
    input  vmul_pkg::instr_type_t                       instr_type_i,
    input  vmul_pkg::sew_t                              sew_i,
    input  logic [vmul_pkg::VL_W-1:0]                   vl_i,
    input  logic [vmul_pkg::VREG_W-1:0]                 vs1_i,
    input  logic [vmul_pkg::VREG_W-1:0]                 vs2_i,
    input  logic [vmul_pkg::VREG_W-1:0]                 vd_old_i,
    output vmul_pkg::bus64_t [vmul_pkg::NUM_LANES-1:0]  lane_vs1_o,
    output vmul_pkg::bus64_t [vmul_pkg::NUM_LANES-1:0]  lane_vs2_o,
    output vmul_pkg::instr_type_t                       instr_type_o,
    output vmul_pkg::sew_t                              sew_o,
    output logic                                        valid_o,
    output logic [vmul_pkg::VREG_BYTES-1:0]             byte_en_o,
    output logic [vmul_pkg::VREG_W-1:0]                 vd_old_o
);

    logic [vmul_pkg::VREG_BYTES-1:0] byte_en_d;

    // byte k belongs to element k >> sew, active while below vl
    always_comb begin
        for (int k = 0; k < vmul_pkg::VREG_BYTES; k++) begin
            byte_en_d[k] = ((k >> int'(sew_i)) < int'(vl_i));
        end
    end

    ////////////////////
    // input register
    ////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o      <= 1'b0;
            instr_type_o <= vmul_pkg::VMUL;
            sew_o        <= vmul_pkg::SEW_8;
            byte_en_o    <= '0;
            lane_vs1_o   <= '0;
            lane_vs2_o   <= '0;
            vd_old_o     <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                instr_type_o <= instr_type_i;
                sew_o        <= sew_i;
                byte_en_o    <= byte_en_d;
                // lane n takes bits [64n+63:64n]
                lane_vs1_o   <= vs1_i;
                lane_vs2_o   <= vs2_i;
                vd_old_o     <= vd_old_i;
            end
        end
    end

    // the group holds 32 bytes, so at most 32 >> sew elements
    vl_in_range_a : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        valid_i |-> (int'(vl_i) <= (vmul_pkg::VREG_BYTES >> int'(sew_i)))
    );

endmodule

// ==== vmul_unit/vmul_lane.sv ====
// 64-bit SIMD multiplier lane, three register stages, output registered.
// Operands are converted to magnitudes, multiplied unsigned and the sign is
// restored at the end. Every element width has the same latency.

module vmul_lane (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  vmul_pkg::instr_type_t instr_type_i,
    input  vmul_pkg::sew_t        sew_i,
    input  vmul_pkg::bus64_t      vs1_i,
    input  vmul_pkg::bus64_t      vs2_i,
    output vmul_pkg::bus64_t      vd_o
);

    ////////////////////
    // stage 0
    ////////////////////

    logic              is_mulh_0;
    logic              src1_signed_0;
    logic              src2_signed_0;
    vmul_pkg::elem64_u src1_u;
    vmul_pkg::elem64_u src2_u;
    vmul_pkg::elem64_u mag1_0;
    vmul_pkg::elem64_u mag2_0;
    logic [7:0]        neg_0;

    // low half is the same for signed and unsigned, VMUL goes signed
    assign is_mulh_0     = (instr_type_i != vmul_pkg::VMUL);
    assign src1_signed_0 = (instr_type_i != vmul_pkg::VMULHU);
    assign src2_signed_0 = (instr_type_i == vmul_pkg::VMUL) || (instr_type_i == vmul_pkg::VMULH);

    assign src1_u = vs1_i;
    assign src2_u = vs2_i;

    // magnitudes and result sign per element
    always_comb begin
        logic n1;
        logic n2;
        n1     = 1'b0;
        n2     = 1'b0;
        mag1_0 = '0;
        mag2_0 = '0;
        neg_0  = '0;
        case (sew_i)
            vmul_pkg::SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    n1 = src1_signed_0 & src1_u.b[i][7];
                    n2 = src2_signed_0 & src2_u.b[i][7];
                    neg_0[i]    = n1 ^ n2;
                    mag1_0.b[i] = n1 ? -src1_u.b[i] : src1_u.b[i];
                    mag2_0.b[i] = n2 ? -src2_u.b[i] : src2_u.b[i];
                end
            end
            vmul_pkg::SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    n1 = src1_signed_0 & src1_u.h[i][15];
                    n2 = src2_signed_0 & src2_u.h[i][15];
                    neg_0[i]    = n1 ^ n2;
                    mag1_0.h[i] = n1 ? -src1_u.h[i] : src1_u.h[i];
                    mag2_0.h[i] = n2 ? -src2_u.h[i] : src2_u.h[i];
                end
            end
            vmul_pkg::SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    n1 = src1_signed_0 & src1_u.w[i][31];
                    n2 = src2_signed_0 & src2_u.w[i][31];
                    neg_0[i]    = n1 ^ n2;
                    mag1_0.w[i] = n1 ? -src1_u.w[i] : src1_u.w[i];
                    mag2_0.w[i] = n2 ? -src2_u.w[i] : src2_u.w[i];
                end
            end
            vmul_pkg::SEW_64: begin
                n1 = src1_signed_0 & src1_u.d[63];
                n2 = src2_signed_0 & src2_u.d[63];
                neg_0[0]  = n1 ^ n2;
                mag1_0.d  = n1 ? -src1_u.d : src1_u.d;
                mag2_0.d  = n2 ? -src2_u.d : src2_u.d;
            end
        endcase
    end

    vmul_pkg::sew_t   sew_1;
    logic             is_mulh_1;
    logic [7:0]       neg_1;
    vmul_pkg::bus64_t mag1_1;
    vmul_pkg::bus64_t mag2_1;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_1     <= vmul_pkg::SEW_8;
            is_mulh_1 <= 1'b0;
            neg_1     <= '0;
            mag1_1    <= '0;
            mag2_1    <= '0;
        end else begin
            sew_1     <= sew_i;
            is_mulh_1 <= is_mulh_0;
            neg_1     <= neg_0;
            mag1_1    <= mag1_0;
            mag2_1    <= mag2_0;
        end
    end

    ////////////////////
    // stage 1
    ////////////////////

    logic [15:0] p8  [8][8];
    logic [31:0] p16 [4][4];
    logic [63:0] p32 [2][2];

    // every byte of vs1 against every byte of vs2, then
    // (hi*2^n + lo)(hi*2^n + lo) folded up to 16 and 32 bits
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                p8[i][j] = 16'(mag1_1[i*8+:8]) * 16'(mag2_1[j*8+:8]);
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                p16[i][j] = 32'(p8[2*i][2*j])
                          + ((32'(p8[2*i][2*j+1]) + 32'(p8[2*i+1][2*j])) << 8)
                          + (32'(p8[2*i+1][2*j+1]) << 16);
            end
        end
        for (int i = 0; i < 2; i++) begin
            for (int j = 0; j < 2; j++) begin
                p32[i][j] = 64'(p16[2*i][2*j])
                          + ((64'(p16[2*i][2*j+1]) + 64'(p16[2*i+1][2*j])) << 16)
                          + (64'(p16[2*i+1][2*j+1]) << 32);
            end
        end
    end

    vmul_pkg::sew_t          sew_2;
    logic                    is_mulh_2;
    logic [7:0]              neg_2;
    logic [7:0][15:0]        p8d_2;
    logic [3:0][31:0]        p16d_2;
    logic [1:0][1:0][63:0]   p32_2;

    // only the diagonal is a real element product below 64 bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_2     <= vmul_pkg::SEW_8;
            is_mulh_2 <= 1'b0;
            neg_2     <= '0;
            p8d_2     <= '0;
            p16d_2    <= '0;
            p32_2     <= '0;
        end else begin
            sew_2     <= sew_1;
            is_mulh_2 <= is_mulh_1;
            neg_2     <= neg_1;
            for (int i = 0; i < 8; i++) begin
                p8d_2[i] <= p8[i][i];
            end
            for (int i = 0; i < 4; i++) begin
                p16d_2[i] <= p16[i][i];
            end
            for (int i = 0; i < 2; i++) begin
                for (int j = 0; j < 2; j++) begin
                    p32_2[i][j] <= p32[i][j];
                end
            end
        end
    end

    ////////////////////
    // stage 2
    ////////////////////

    logic [127:0]      prod64_2;
    logic [127:0]      wide_2;
    vmul_pkg::elem64_u res_2;
    vmul_pkg::bus64_t  vd_q;

    // full signed products, element i at bits [i*2W +: 2W]
    always_comb begin
        prod64_2 = 128'(p32_2[0][0])
                 + ((128'(p32_2[0][1]) + 128'(p32_2[1][0])) << 32)
                 + (128'(p32_2[1][1]) << 64);
        wide_2 = '0;
        case (sew_2)
            vmul_pkg::SEW_8: begin
                for (int i = 0; i < 8; i++) begin
                    wide_2[i*16+:16] = neg_2[i] ? -p8d_2[i] : p8d_2[i];
                end
            end
            vmul_pkg::SEW_16: begin
                for (int i = 0; i < 4; i++) begin
                    wide_2[i*32+:32] = neg_2[i] ? -p16d_2[i] : p16d_2[i];
                end
            end
            vmul_pkg::SEW_32: begin
                for (int i = 0; i < 2; i++) begin
                    wide_2[i*64+:64] = neg_2[i] ? -p32_2[i][i] : p32_2[i][i];
                end
            end
            vmul_pkg::SEW_64: begin
                wide_2 = neg_2[0] ? -prod64_2 : prod64_2;
            end
        endcase
    end

    // half select, one byte path for all widths
    always_comb begin
        int esize;
        int src;
        esize = 1 << int'(sew_2);
        src   = 0;
        for (int k = 0; k < 8; k++) begin
            src = ((((k >> int'(sew_2)) * 2) + int'(is_mulh_2)) << int'(sew_2))
                + (k & (esize - 1));
            res_2.b[k] = wide_2[src*8+:8];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vd_q <= '0;
        end else begin
            vd_q <= res_2;
        end
    end

    assign vd_o = vd_q;

    // element width travels with the data through every stage
    sew_known_a : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !$isunknown({sew_i, sew_1, sew_2})
    );

endmodule

// ==== vmul_unit/vmul_collect.sv ====
// Output stage. Valid, byte mask and old destination are delayed to meet
// the lane results; tail bytes keep the old destination.
// vd_o only changes on a valid result and holds it otherwise.

module vmul_collect (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  logic                                        valid_i,
    input  logic [vmul_pkg::VREG_BYTES-1:0]             byte_en_i,
    input  logic [vmul_pkg::VREG_W-1:0]                 vd_old_i,
    input  vmul_pkg::bus64_t [vmul_pkg::NUM_LANES-1:0]  lane_vd_i,
    output logic                                        valid_o,
    output logic [vmul_pkg::VREG_W-1:0]                 vd_o
);

    localparam int LAT = vmul_pkg::LANE_LATENCY;

    logic [LAT-1:0]                                valid_dly;
    logic [LAT-1:0][vmul_pkg::VREG_BYTES-1:0]      be_dly;
    logic [LAT-1:0][vmul_pkg::VREG_W-1:0]          old_dly;
    logic [vmul_pkg::VREG_W-1:0]                   lane_flat;
    logic [vmul_pkg::VREG_W-1:0]                   merged;

    // delay line, entry LAT-1 lines up with the lane outputs
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_dly <= '0;
            be_dly    <= '0;
            old_dly   <= '0;
        end else begin
            valid_dly <= {valid_dly[LAT-2:0], valid_i};
            be_dly    <= {be_dly[LAT-2:0], byte_en_i};
            old_dly   <= {old_dly[LAT-2:0], vd_old_i};
        end
    end

    assign lane_flat = lane_vd_i;

    // byte merge
    always_comb begin
        for (int b = 0; b < vmul_pkg::VREG_BYTES; b++) begin
            merged[b*8+:8] = be_dly[LAT-1][b] ? lane_flat[b*8+:8] : old_dly[LAT-1][b*8+:8];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
            vd_o    <= '0;
        end else begin
            valid_o <= valid_dly[LAT-1];
            if (valid_dly[LAT-1]) begin
                vd_o <= merged;
            end
        end
    end

    // back to back outputs need back to back inputs
    valid_pair_a : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (valid_o && $past(valid_o)) |-> ($past(valid_i, LAT + 1) && $past(valid_i, LAT + 2))
    );

endmodule

// ==== vmul_unit/vmul_unit.sv ====
// Vector integer multiply unit for one 256-bit register group.
// One operation per clock, no back-pressure, result 5 edges after input.

module vmul_unit (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        valid_i,
    input  vmul_pkg::instr_type_t       instr_type_i,
    input  vmul_pkg::sew_t              sew_i,
    input  logic [vmul_pkg::VL_W-1:0]   vl_i,
    input  logic [vmul_pkg::VREG_W-1:0] vs1_i,
    input  logic [vmul_pkg::VREG_W-1:0] vs2_i,
    input  logic [vmul_pkg::VREG_W-1:0] vd_old_i,
    output logic                        valid_o,
    output logic [vmul_pkg::VREG_W-1:0] vd_o
);

    vmul_pkg::bus64_t [vmul_pkg::NUM_LANES-1:0] lane_vs1;
    vmul_pkg::bus64_t [vmul_pkg::NUM_LANES-1:0] lane_vs2;
    vmul_pkg::bus64_t [vmul_pkg::NUM_LANES-1:0] lane_vd;
    vmul_pkg::instr_type_t                      instr_type;
    vmul_pkg::sew_t                             sew;
    logic                                       disp_valid;
    logic [vmul_pkg::VREG_BYTES-1:0]            byte_en;
    logic [vmul_pkg::VREG_W-1:0]                vd_old;

    vmul_dispatch u_dispatch (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_i      (valid_i),
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .vl_i         (vl_i),
        .vs1_i        (vs1_i),
        .vs2_i        (vs2_i),
        .vd_old_i     (vd_old_i),
        .lane_vs1_o   (lane_vs1),
        .lane_vs2_o   (lane_vs2),
        .instr_type_o (instr_type),
        .sew_o        (sew),
        .valid_o      (disp_valid),
        .byte_en_o    (byte_en),
        .vd_old_o     (vd_old)
    );

    // lanes share opcode and width
    for (genvar g = 0; g < vmul_pkg::NUM_LANES; g++) begin : g_lane
        vmul_lane u_lane (
            .clk_i        (clk_i),
            .rstn_i       (rstn_i),
            .instr_type_i (instr_type),
            .sew_i        (sew),
            .vs1_i        (lane_vs1[g]),
            .vs2_i        (lane_vs2[g]),
            .vd_o         (lane_vd[g])
        );
    end

    vmul_collect u_collect (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .valid_i   (disp_valid),
        .byte_en_i (byte_en),
        .vd_old_i  (vd_old),
        .lane_vd_i (lane_vd),
        .valid_o   (valid_o),
        .vd_o      (vd_o)
    );

endmodule

// ==== testbench/tb_vmul_unit.sv ====
// Testbench for the vector multiply unit. Expected results come from a
// 128-bit reference model; concurrent assertions check timing and data.
// Operands come from a fixed-seed xorshift generator.

module tb_vmul_unit;

    localparam int PERIOD   = 100;
    localparam int NUM_RAND = 40;
    localparam int NUM_OPS  = 28 + NUM_RAND;

    logic                        clk_i;
    logic                        rstn_i;
    logic                        valid_i;
    vmul_pkg::instr_type_t       instr_type_i;
    vmul_pkg::sew_t              sew_i;
    logic [vmul_pkg::VL_W-1:0]   vl_i;
    logic [vmul_pkg::VREG_W-1:0] vs1_i;
    logic [vmul_pkg::VREG_W-1:0] vs2_i;
    logic [vmul_pkg::VREG_W-1:0] vd_old_i;
    logic                        valid_o;
    logic [vmul_pkg::VREG_W-1:0] vd_o;

    logic [31:0]      rng_state;
    logic [255:0]     exp_vd;
    logic [2:0]       tid_in;
    logic             started;
    logic [4:0]       vld_dly;
    logic [4:0][255:0] exp_dly;
    logic [4:0][2:0]  tid_dly;
    logic [255:0]     pend_q [$];
    logic [255:0]     exp_head;

    vmul_unit DUT (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_i      (valid_i),
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .vl_i         (vl_i),
        .vs1_i        (vs1_i),
        .vs2_i        (vs2_i),
        .vd_old_i     (vd_old_i),
        .valid_o      (valid_o),
        .vd_o         (vd_o)
    );

    always #(PERIOD / 2) clk_i = ~clk_i;

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [255:0] rand_vec();
        logic [255:0] v;
        for (int i = 0; i < 8; i++) begin
            v[i*32+:32] = next_rand();
        end
        return v;
    endfunction

    // same element value in every slot
    function automatic logic [255:0] splat(input vmul_pkg::sew_t sew, input logic [63:0] v);
        logic [255:0] r;
        int           w;
        w = 8 << int'(sew);
        r = '0;
        for (int e = 0; e < 256 / w; e++) begin
            for (int k = 0; k < w; k++) begin
                r[e*w+k] = v[k];
            end
        end
        return r;
    endfunction

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd0:    return "vmul_low_half";
            3'd1:    return "vmulh_vmulhu_edges";
            3'd2:    return "vmulhsu_mixed";
            3'd3:    return "tail_undisturbed";
            default: return "random_back_to_back";
        endcase
    endfunction

    // reference model takes the full product in 128 bits and selects the half
    function automatic logic [255:0] expect_result(
        input vmul_pkg::instr_type_t op, input vmul_pkg::sew_t sew, input int vl,
        input logic [255:0] a_vec, input logic [255:0] b_vec, input logic [255:0] old_vec);
        int           w;
        logic         a_signed;
        logic         b_signed;
        logic [127:0] mask;
        logic [127:0] a;
        logic [127:0] b;
        logic [127:0] p;
        logic [127:0] half;
        logic [255:0] r;
        w        = 8 << int'(sew);
        a_signed = (op == vmul_pkg::VMULH) || (op == vmul_pkg::VMULHSU);
        b_signed = (op == vmul_pkg::VMULH);
        mask     = (128'(1) << w) - 128'(1);
        r        = old_vec;
        for (int e = 0; e < 256 / w; e++) begin
            if (e < vl) begin
                a = 128'(a_vec >> (e * w)) & mask;
                b = 128'(b_vec >> (e * w)) & mask;
                if (a_signed && a[w-1]) a = a | ~mask;
                if (b_signed && b[w-1]) b = b | ~mask;
                p    = a * b;
                half = (op == vmul_pkg::VMUL) ? p : (p >> w);
                for (int k = 0; k < w; k++) begin
                    r[e*w+k] = half[k];
                end
            end
        end
        return r;
    endfunction

    task automatic send_op(input logic [2:0] tid, input vmul_pkg::instr_type_t op,
                           input vmul_pkg::sew_t sew, input int vl, input logic [255:0] a_vec,
                           input logic [255:0] b_vec, input logic [255:0] old_vec);
        logic [255:0] exp_val;
        exp_val = expect_result(op, sew, vl, a_vec, b_vec, old_vec);
        @(posedge clk_i);
        valid_i      <= 1'b1;
        instr_type_i <= op;
        sew_i        <= sew;
        vl_i         <= vmul_pkg::VL_W'(vl);
        vs1_i        <= a_vec;
        vs2_i        <= b_vec;
        vd_old_i     <= old_vec;
        exp_vd       <= exp_val;
        tid_in       <= tid;
        started      <= 1'b1;
        pend_q.push_back(exp_val);
    endtask

    ////////////////////
    // checks
    ////////////////////

    // expected values ride along with the input strobe
    always @(posedge clk_i) begin
        vld_dly <= {vld_dly[3:0], valid_i};
        exp_dly <= {exp_dly[3:0], exp_vd};
        tid_dly <= {tid_dly[3:0], tid_in};
        // results leave in issue order
        if (rstn_i && valid_o) begin
            if (pend_q.size() == 0) begin
                $display("DUT returned a result with no operation outstanding");
                $display("Some tests failed");
                $fatal(1);
            end else begin
                exp_head = pend_q.pop_front();
                in_order_a : assert (vd_o == exp_head) else begin
                    $display("Fail %s (issue order): expected %h, actual %h",
                             test_label(tid_dly[4]), exp_head, vd_o);
                    $display("Some tests failed");
                    $fatal(1);
                end
            end
        end
    end

    idle_after_reset_a : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !started |-> (!valid_o && vd_o == '0)
    ) else begin
        $display("Fail after_reset: expected valid_o 0 and vd_o 0, actual %0b and %h",
                 $sampled(valid_o), $sampled(vd_o));
        $display("Some tests failed");
        $fatal(1);
    end

    latency_a : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        valid_o == vld_dly[4]
    ) else begin
        $display("Fail latency: expected valid_o %0b, actual %0b",
                 $sampled(vld_dly[4]), $sampled(valid_o));
        $display("Some tests failed");
        $fatal(1);
    end

    result_a : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> (vd_o == exp_dly[4])
    ) else begin
        $display("Fail %s: expected %h, actual %h", test_label($sampled(tid_dly[4])),
                 $sampled(exp_dly[4]), $sampled(vd_o));
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin
        #((NUM_OPS + 20) * PERIOD);
        $display("watchdog expired before all results came back");
        $display("Some tests failed");
        $fatal(1);
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        logic [255:0]          a;
        logic [255:0]          b;
        logic [255:0]          c;
        logic [63:0]           min_neg;
        logic [31:0]           r;
        vmul_pkg::sew_t        s;
        int                    full;
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        valid_i       = 1'b0;
        instr_type_i  = vmul_pkg::VMUL;
        sew_i         = vmul_pkg::SEW_8;
        vl_i          = '0;
        vs1_i         = '0;
        vs2_i         = '0;
        vd_old_i      = '0;
        exp_vd        = '0;
        exp_head      = '0;
        tid_in        = '0;
        started       = 1'b0;
        vld_dly       = '0;
        exp_dly       = '0;
        tid_dly       = '0;
        rng_state     = 32'h2be4a293;
        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        // outputs must stay quiet here
        repeat (3) @(posedge clk_i);

        for (int i = 0; i < 4; i++) begin
            s       = vmul_pkg::sew_t'(i);
            full    = 32 >> i;
            min_neg = 64'(1) << ((8 << i) - 1);
            a = rand_vec();
            b = rand_vec();
            c = rand_vec();
            send_op(3'd0, vmul_pkg::VMUL, s, full, a, b, c);
            send_op(3'd1, vmul_pkg::VMULH, s, full, splat(s, min_neg), splat(s, min_neg), c);
            send_op(3'd1, vmul_pkg::VMULH, s, full, splat(s, min_neg), '1, c);
            send_op(3'd1, vmul_pkg::VMULHU, s, full, '1, '1, c);
            send_op(3'd2, vmul_pkg::VMULHSU, s, full, a, b, c);
            send_op(3'd3, vmul_pkg::VMULH, s, 0, a, b, c);
            r = next_rand();
            send_op(3'd3, vmul_pkg::VMUL, s, int'(r % full), a, b, c);
        end

        // random operations back to back on every clock
        for (int i = 0; i < NUM_RAND; i++) begin
            r    = next_rand();
            s    = vmul_pkg::sew_t'(r[3:2]);
            full = 32 >> int'(r[3:2]);
            a = rand_vec();
            b = rand_vec();
            c = rand_vec();
            send_op(3'd4, vmul_pkg::instr_type_t'(r[1:0]), s, int'(r[31:8]) % (full + 1),
                    a, b, c);
        end
        @(posedge clk_i);
        valid_i <= 1'b0;

        while (pend_q.size() != 0) begin
            @(posedge clk_i);
        end
        // let the last check settle
        @(posedge clk_i);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== sources.f ====
common/vmul_pkg.sv
vmul_unit/vmul_dispatch.sv
vmul_unit/vmul_lane.sv
vmul_unit/vmul_collect.sv
vmul_unit/vmul_unit.sv
testbench/tb_vmul_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_vmul_unit
RTL_TOP   ?= vmul_unit
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
